// File: hdl/lc_pkg.sv
// --------------------
// Lifecycle package
// Compact lifecycle codes, the enable code and fuse-side structs
// --------------------

package lc_pkg;

  // --------------------
  // Lifecycle state code
  // Codes 21 to 31 are invalid
  typedef enum logic [4:0] {
    lc_st_raw            = 5'd0,
    lc_st_test_unlocked0 = 5'd1,
    lc_st_test_unlocked1 = 5'd2,
    lc_st_test_unlocked2 = 5'd3,
    lc_st_test_unlocked3 = 5'd4,
    lc_st_test_unlocked4 = 5'd5,
    lc_st_test_unlocked5 = 5'd6,
    lc_st_test_unlocked6 = 5'd7,
    lc_st_test_unlocked7 = 5'd8,
    lc_st_test_locked0   = 5'd9,
    lc_st_test_locked1   = 5'd10,
    lc_st_test_locked2   = 5'd11,
    lc_st_test_locked3   = 5'd12,
    lc_st_test_locked4   = 5'd13,
    lc_st_test_locked5   = 5'd14,
    lc_st_test_locked6   = 5'd15,
    lc_st_dev            = 5'd16,
    lc_st_prod           = 5'd17,
    lc_st_prod_end       = 5'd18,
    lc_st_rma            = 5'd19,
    lc_st_scrap          = 5'd20
  } lc_state_e;

  // Multi-bit enable, anything but on counts as off
  typedef enum logic [3:0] {
    lc_tx_on  = 4'b0101,
    lc_tx_off = 4'b1010
  } lc_tx_e;

  // Fuse controller report of the stored state
  typedef struct packed {
    logic      valid;
    lc_state_e state;
  } otp_lc_data_t;

  // Program request from the lifecycle controller
  typedef struct packed {
    logic      req;
    lc_state_e state;
  } lc_otp_prog_t;

endpackage

// File: hdl/sec_pkg.sv
// --------------------
// Security state package
// Security state types, translator states and the decoded request
// --------------------

package sec_pkg;

  // Device lifecycle kind seen by the core
  typedef enum logic [1:0] {
    dev_unprovisioned = 2'b00,
    dev_manufacturing = 2'b01,
    dev_production    = 2'b11
  } device_lifecycle_e;

  typedef struct packed {
    device_lifecycle_e device_lifecycle;
    logic              debug_locked;
  } security_state_t;

  // Locked production, used on reset, invalid data and faults
  localparam security_state_t sec_default_c = '{
    device_lifecycle: dev_production,
    debug_locked:     1'b1
  };

  // --------------------
  // Lifecycle class, zero is the safe non-debug class
  typedef enum logic [2:0] {
    cls_non_debug = 3'd0,
    cls_unprov    = 3'd1,
    cls_manuf     = 3'd2,
    cls_prod      = 3'd3,
    cls_rma       = 3'd4,
    cls_unknown   = 3'd5
  } lc_class_e;

  typedef enum logic [2:0] {
    trans_reset, trans_idle, trans_non_debug, trans_unprov_debug,
    trans_manuf_non_debug, trans_manuf_debug, trans_prod_non_debug, trans_prod_debug
  } trans_state_e;

  // Decoded request, all zero means nothing unlocked
  typedef struct packed {
    lc_class_e lc_class;
    logic      scrap_req;
    logic      scrap_static;
    logic      dft_req;
    logic      hw_dbg_req;
    logic      prod_unlock;
    logic      manuf_en;
    logic      volatile_unlock;
    logic      state_error;
    logic      warm_warn;
  } lc_req_t;

endpackage

// File: hdl/lc_decode.sv
// --------------------
// Lifecycle decoder
// Classifies the fuse state and evaluates the debug unlock masks
// --------------------

`timescale 1ns/1ps

module lc_decode
  import lc_pkg::*;
  import sec_pkg::*;
#(
  parameter int unsigned DbgLevels = 64
) (
  input  otp_lc_data_t         otp_data_i,
  input  lc_otp_prog_t         lc_prog_i,
  input  lc_tx_e               lc_dft_en_i,
  input  lc_tx_e               lc_hw_debug_en_i,
  input  logic                 manuf_dbg_en_i,
  input  logic                 volatile_unlock_i,
  input  logic                 state_error_i,
  input  logic                 warm_reset_warn_i,
  input  logic [DbgLevels-1:0] unlock_level_i,
  input  logic [DbgLevels-1:0] dft_mask_i,
  input  logic [DbgLevels-1:0] dbg_mask_i,
  input  logic [DbgLevels-1:0] cltap_mask_i,
  output lc_req_t              req_o
);

  lc_state_e fuse_state;
  lc_class_e fuse_class;
  lc_req_t   req;

  assign fuse_state = otp_data_i.state;

  // --------------------
  // State classification
  always_comb begin
    if (fuse_state inside {lc_st_raw, [lc_st_test_locked0:lc_st_test_locked6], lc_st_scrap}) begin
      // Scrap is kept locked here and flagged on its own below
      fuse_class = cls_non_debug;
    end else if (fuse_state inside {[lc_st_test_unlocked0:lc_st_test_unlocked7]}) begin
      fuse_class = cls_unprov;
    end else if (fuse_state == lc_st_dev) begin
      fuse_class = cls_manuf;
    end else if (fuse_state inside {lc_st_prod, lc_st_prod_end}) begin
      fuse_class = cls_prod;
    end else if (fuse_state == lc_st_rma) begin
      fuse_class = cls_rma;
    end else begin
      // Codes above scrap
      fuse_class = cls_unknown;
    end
  end

  // --------------------
  // Request terms
  always_comb begin
    req.lc_class        = fuse_class;
    req.scrap_req       = lc_prog_i.req && (lc_prog_i.state == lc_st_scrap);
    req.scrap_static    = (fuse_state == lc_st_scrap);
    // Manufacturing unlock only has one level, mapped to mask bit 0
    req.dft_req         = (lc_dft_en_i == lc_tx_on)
                        | (|(unlock_level_i & dft_mask_i))
                        | (manuf_dbg_en_i & dft_mask_i[0]);
    req.hw_dbg_req      = (lc_hw_debug_en_i == lc_tx_on)
                        | (|(unlock_level_i & cltap_mask_i));
    req.prod_unlock     = |(unlock_level_i & dbg_mask_i);
    req.manuf_en        = manuf_dbg_en_i;
    req.volatile_unlock = volatile_unlock_i;
    req.state_error     = state_error_i;
    req.warm_warn       = warm_reset_warn_i;
  end

  // Nothing leaves the decoder while the fuse data is not valid
  assign req_o = otp_data_i.valid ? req : '0;

endmodule

// File: hdl/lc_snapshot.sv
// --------------------
// Request snapshot
// Registers the decoded request and fuse state while data is valid
// --------------------

`timescale 1ns/1ps

module lc_snapshot
  import lc_pkg::*;
  import sec_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      valid_i,
  input  lc_state_e state_i,
  input  lc_req_t   req_i,
  output logic      valid_o,
  output lc_state_e state_o,
  output lc_req_t   req_o
);

  logic      valid_q;
  lc_state_e state_q;
  lc_req_t   req_q;

  // --------------------
  // Capture register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      state_q <= lc_st_raw;
      req_q   <= '0;
    end else begin
      valid_q <= valid_i;
      if (valid_i) begin
        state_q <= state_i;
        req_q   <= req_i;
      end else begin
        // Drop any unlock left over from the last valid cycle
        state_q <= lc_st_raw;
        req_q   <= '0;
      end
    end
  end

  assign valid_o = valid_q;
  assign state_o = state_q;
  assign req_o   = req_q;

endmodule

// File: hdl/sec_translator.sv
// --------------------
// Security state translator
// FSM from lifecycle class to security state, plus the SoC enables
// --------------------

`timescale 1ns/1ps

module sec_translator
  import sec_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            valid_i,
  input  lc_req_t         req_i,
  output security_state_t security_state_o,
  output logic            dft_en_o,
  output logic            hw_debug_en_o
);

  trans_state_e    state_q;
  trans_state_e    state_d;
  security_state_t sec_d;
  logic            kill;

  // Scrap request or state error pulls every state back to non-debug
  assign kill = req_i.scrap_req | req_i.state_error;

  // --------------------
  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      trans_reset: begin
        // Register only advances while valid, so this is the first valid edge
        state_d = trans_idle;
      end
      trans_idle: begin
        if (kill || req_i.scrap_static) begin
          state_d = trans_non_debug;
        end else begin
          case (req_i.lc_class)
            cls_non_debug: state_d = trans_non_debug;
            cls_unprov:    state_d = trans_unprov_debug;
            cls_manuf:     state_d = trans_manuf_non_debug;
            cls_prod:      state_d = trans_prod_non_debug;
            cls_rma:       state_d = trans_prod_debug;
            // Invalid codes wait in idle with the locked default
            default:       state_d = trans_idle;
          endcase
        end
      end
      trans_non_debug: begin
        // Volatile raw unlock
        if (req_i.volatile_unlock && !kill) begin
          state_d = trans_unprov_debug;
        end
      end
      trans_manuf_non_debug: begin
        if (kill) begin
          state_d = trans_non_debug;
        end else if (req_i.manuf_en) begin
          state_d = trans_manuf_debug;
        end
      end
      trans_prod_non_debug: begin
        if (kill) begin
          state_d = trans_non_debug;
        end else if (req_i.prod_unlock) begin
          state_d = trans_prod_debug;
        end
      end
      trans_unprov_debug, trans_manuf_debug, trans_prod_debug: begin
        if (kill) begin
          state_d = trans_non_debug;
        end
      end
      default: begin
        state_d = trans_idle;
      end
    endcase
  end

  // --------------------
  // Security value per state
  always_comb begin
    sec_d = sec_default_c;
    // A kill locks the output in the same cycle it moves the state
    if (!kill) begin
      case (state_q)
        trans_unprov_debug: begin
          sec_d = '{device_lifecycle: dev_unprovisioned, debug_locked: 1'b0};
        end
        trans_manuf_non_debug: begin
          sec_d = '{device_lifecycle: dev_manufacturing, debug_locked: 1'b1};
        end
        trans_manuf_debug: begin
          sec_d = '{device_lifecycle: dev_manufacturing, debug_locked: 1'b0};
        end
        trans_prod_debug: begin
          sec_d = '{device_lifecycle: dev_production, debug_locked: 1'b0};
        end
        // Reset, idle, non-debug and prod non-debug stay locked production
        default: begin
          sec_d = sec_default_c;
        end
      endcase
    end
  end

  // --------------------
  // State and output registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= trans_reset;
      security_state_o <= sec_default_c;
      dft_en_o         <= 1'b0;
      hw_debug_en_o    <= 1'b0;
    end else if (valid_i) begin
      state_q          <= state_d;
      // Warm reset warning forces the locked value, state is kept
      security_state_o <= req_i.warm_warn ? sec_default_c : sec_d;
      dft_en_o         <= req_i.dft_req & ~req_i.scrap_req;
      hw_debug_en_o    <= req_i.hw_dbg_req & ~req_i.scrap_req;
    end else begin
      state_q          <= trans_reset;
      security_state_o <= sec_default_c;
      dft_en_o         <= 1'b0;
      hw_debug_en_o    <= 1'b0;
    end
  end

endmodule

// File: hdl/lc_sec_top.sv
// --------------------
// Lifecycle to security state top
// Decoder, snapshot register and translator FSM in a chain
// --------------------

`timescale 1ns/1ps

module lc_sec_top
  import lc_pkg::*;
  import sec_pkg::*;
#(
  parameter int unsigned DbgLevels = 64
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  otp_lc_data_t         otp_data_i,
  input  lc_otp_prog_t         lc_prog_i,
  input  lc_tx_e               lc_dft_en_i,
  input  lc_tx_e               lc_hw_debug_en_i,
  input  logic                 manuf_dbg_en_i,
  input  logic                 volatile_unlock_i,
  input  logic                 state_error_i,
  input  logic                 warm_reset_warn_i,
  input  logic [DbgLevels-1:0] unlock_level_i,
  input  logic [DbgLevels-1:0] dft_mask_i,
  input  logic [DbgLevels-1:0] dbg_mask_i,
  input  logic [DbgLevels-1:0] cltap_mask_i,
  output security_state_t      security_state_o,
  output logic                 soc_dft_en_o,
  output logic                 soc_hw_debug_en_o,
  output logic                 otp_state_valid_o,
  output lc_state_e            lc_state_o
);

  lc_req_t req_d;
  lc_req_t req_q;
  logic    snap_valid;

  // Combinational decode of the raw inputs
  lc_decode #(
    .DbgLevels(DbgLevels)
  ) lc_decode_i (
    .otp_data_i       (otp_data_i),
    .lc_prog_i        (lc_prog_i),
    .lc_dft_en_i      (lc_dft_en_i),
    .lc_hw_debug_en_i (lc_hw_debug_en_i),
    .manuf_dbg_en_i   (manuf_dbg_en_i),
    .volatile_unlock_i(volatile_unlock_i),
    .state_error_i    (state_error_i),
    .warm_reset_warn_i(warm_reset_warn_i),
    .unlock_level_i   (unlock_level_i),
    .dft_mask_i       (dft_mask_i),
    .dbg_mask_i       (dbg_mask_i),
    .cltap_mask_i     (cltap_mask_i),
    .req_o            (req_d)
  );

  // One cycle snapshot, also the static state output
  lc_snapshot lc_snapshot_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(otp_data_i.valid),
    .state_i(otp_data_i.state),
    .req_i  (req_d),
    .valid_o(snap_valid),
    .state_o(lc_state_o),
    .req_o  (req_q)
  );

  sec_translator sec_translator_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .valid_i         (snap_valid),
    .req_i           (req_q),
    .security_state_o(security_state_o),
    .dft_en_o        (soc_dft_en_o),
    .hw_debug_en_o   (soc_hw_debug_en_o)
  );

  // Valid flag passes straight through
  assign otp_state_valid_o = otp_data_i.valid;

endmodule

// File: tb/lc_sec_chk.sv
// --------------------
// Bound checker for the lifecycle translator top
// Default outputs, scrap gating and state error locking
// --------------------

`timescale 1ns/1ps

module lc_sec_chk
  import lc_pkg::*;
  import sec_pkg::*;
(
  input logic            clk_i,
  input logic            rst_ni,
  input logic            valid_i,
  input lc_otp_prog_t    lc_prog_i,
  input logic            state_error_i,
  input security_state_t security_state_i,
  input logic            dft_en_i,
  input logic            hw_debug_en_i,
  input lc_state_e       lc_state_i
);

  // Failure count for the closing summary
  int unsigned fail_cnt;

  initial fail_cnt = 0;

  // Two low valid edges clear the whole pipeline
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!valid_i ##1 !valid_i) |=> (security_state_i == sec_default_c && !dft_en_i &&
                                 !hw_debug_en_i && lc_state_i == lc_st_raw))
    else begin
      fail_cnt++;
      $error("outputs left their defaults while valid was low");
    end

  // Scrap program request clears both enables once it has passed the snapshot
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lc_prog_i.req && lc_prog_i.state == lc_st_scrap) |=> ##1 (!dft_en_i && !hw_debug_en_i))
    else begin
      fail_cnt++;
      $error("an enable stayed high after a scrap request");
    end

  // Held state error keeps debug locked
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_error_i [*4] |-> security_state_i.debug_locked)
    else begin
      fail_cnt++;
      $error("debug unlocked while a state error was held");
    end

endmodule

// File: tb/lc_sec_model.svh
// --------------------
// Reference model for the lifecycle translator
// Class map, translator transitions and expected security value
// --------------------

`ifndef LC_SEC_MODEL_SVH
`define LC_SEC_MODEL_SVH

// Class from the numeric lifecycle code
function automatic lc_class_e classify_state(input lc_state_e st);
  logic [4:0] c;
  c = st;
  if (c == 5'd0 || (c >= 5'd9 && c <= 5'd15) || c == 5'd20) return cls_non_debug;
  if (c >= 5'd1 && c <= 5'd8) return cls_unprov;
  if (c == 5'd16) return cls_manuf;
  if (c == 5'd17 || c == 5'd18) return cls_prod;
  if (c == 5'd19) return cls_rma;
  return cls_unknown;
endfunction

// Request terms from the current stimulus, valid assumed high
function automatic lc_req_t build_request();
  lc_req_t r;
  r = '0;
  r.lc_class        = classify_state(otp_data.state);
  r.scrap_req       = lc_prog.req && (lc_prog.state == lc_st_scrap);
  r.scrap_static    = (otp_data.state == lc_st_scrap);
  r.dft_req         = (lc_dft_en == lc_tx_on) || ((unlock_level & dft_mask) != '0)
                   || (manuf_dbg_en && dft_mask[0]);
  r.hw_dbg_req      = (lc_hw_debug_en == lc_tx_on) || ((unlock_level & cltap_mask) != '0);
  r.prod_unlock     = (unlock_level & dbg_mask) != '0;
  r.manuf_en        = manuf_dbg_en;
  r.volatile_unlock = volatile_unlock;
  r.state_error     = state_error;
  r.warm_warn       = warm_reset_warn;
  return r;
endfunction

// One translator step
function automatic trans_state_e step_state(input trans_state_e st, input lc_req_t r);
  logic kill;
  kill = r.scrap_req || r.state_error;
  case (st)
    trans_reset: return trans_idle;
    trans_idle: begin
      if (kill || r.scrap_static) return trans_non_debug;
      case (r.lc_class)
        cls_non_debug: return trans_non_debug;
        cls_unprov:    return trans_unprov_debug;
        cls_manuf:     return trans_manuf_non_debug;
        cls_prod:      return trans_prod_non_debug;
        cls_rma:       return trans_prod_debug;
        default:       return trans_idle;
      endcase
    end
    trans_non_debug:       return (r.volatile_unlock && !kill) ? trans_unprov_debug : st;
    trans_manuf_non_debug: return kill ? trans_non_debug : (r.manuf_en ? trans_manuf_debug : st);
    trans_prod_non_debug:  return kill ? trans_non_debug : (r.prod_unlock ? trans_prod_debug : st);
    default:               return kill ? trans_non_debug : st;
  endcase
endfunction

// Steady state with stable inputs
function automatic trans_state_e settle_state(input trans_state_e st, input lc_req_t r);
  trans_state_e s;
  s = st;
  repeat (4) s = step_state(s, r);
  return s;
endfunction

function automatic security_state_t security_value(input trans_state_e st, input lc_req_t r);
  if (r.warm_warn || r.scrap_req || r.state_error) return sec_default_c;
  case (st)
    trans_unprov_debug:    return '{device_lifecycle: dev_unprovisioned, debug_locked: 1'b0};
    trans_manuf_non_debug: return '{device_lifecycle: dev_manufacturing, debug_locked: 1'b1};
    trans_manuf_debug:     return '{device_lifecycle: dev_manufacturing, debug_locked: 1'b0};
    trans_prod_debug:      return '{device_lifecycle: dev_production, debug_locked: 1'b0};
    default:               return sec_default_c;
  endcase
endfunction

`endif

// File: tb/tb_lc_sec.sv
// --------------------
// Testbench for the lifecycle translator
// LFSR stimulus per scenario checked against the reference model
// --------------------

`timescale 1ns/1ps

module tb_lc_sec
  import lc_pkg::*;
  import sec_pkg::*;
;

  localparam int unsigned DbgLevels = 64;
  localparam int unsigned NumScen   = 300;

  logic clk;
  logic rst_n;
  otp_lc_data_t otp_data;
  lc_otp_prog_t lc_prog;
  lc_tx_e lc_dft_en;
  lc_tx_e lc_hw_debug_en;
  logic manuf_dbg_en;
  logic volatile_unlock;
  logic state_error;
  logic warm_reset_warn;
  logic [DbgLevels-1:0] unlock_level;
  logic [DbgLevels-1:0] dft_mask;
  logic [DbgLevels-1:0] dbg_mask;
  logic [DbgLevels-1:0] cltap_mask;
  security_state_t security_state_o;
  logic soc_dft_en_o;
  logic soc_hw_debug_en_o;
  logic otp_state_valid_o;
  lc_state_e lc_state_o;
  // 17 bit LFSR with taps at bits 17 and 14
  logic [16:0] lfsr_q;
  int unsigned check_cnt;
  int unsigned err_cnt;
  trans_state_e exp_st;

  `include "lc_sec_model.svh"

  lc_sec_top #(
    .DbgLevels(DbgLevels)
  ) lc_sec_top_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .otp_data_i       (otp_data),
    .lc_prog_i        (lc_prog),
    .lc_dft_en_i      (lc_dft_en),
    .lc_hw_debug_en_i (lc_hw_debug_en),
    .manuf_dbg_en_i   (manuf_dbg_en),
    .volatile_unlock_i(volatile_unlock),
    .state_error_i    (state_error),
    .warm_reset_warn_i(warm_reset_warn),
    .unlock_level_i   (unlock_level),
    .dft_mask_i       (dft_mask),
    .dbg_mask_i       (dbg_mask),
    .cltap_mask_i     (cltap_mask),
    .security_state_o (security_state_o),
    .soc_dft_en_o     (soc_dft_en_o),
    .soc_hw_debug_en_o(soc_hw_debug_en_o),
    .otp_state_valid_o(otp_state_valid_o),
    .lc_state_o       (lc_state_o)
  );

  bind lc_sec_top lc_sec_chk lc_sec_chk_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .valid_i         (otp_data_i.valid),
    .lc_prog_i       (lc_prog_i),
    .state_error_i   (state_error_i),
    .security_state_i(security_state_o),
    .dft_en_i        (soc_dft_en_o),
    .hw_debug_en_i   (soc_hw_debug_en_o),
    .lc_state_i      (lc_state_o)
  );

  always #10 clk = ~clk;

  // --------------------
  // One LFSR step per random bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[15:0], lfsr_q[16] ^ lfsr_q[13]};
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // All outputs at reset values while valid is low
  task automatic expect_defaults(input int unsigned scen);
    string tag;
    tag = $sformatf("s%0d idle", scen);
    compare_value({tag, " sec_state"}, sec_default_c, security_state_o);
    compare_value({tag, " dft_en"}, 8'd0, soc_dft_en_o);
    compare_value({tag, " hw_debug_en"}, 8'd0, soc_hw_debug_en_o);
    compare_value({tag, " otp_valid"}, 8'd0, otp_state_valid_o);
    compare_value({tag, " lc_state"}, lc_st_raw, lc_state_o);
  endtask

  task automatic check_outputs(input int unsigned scen, input string phase);
    lc_req_t r;
    string tag;
    r = build_request();
    tag = $sformatf("s%0d %s", scen, phase);
    compare_value({tag, " sec_state"}, security_value(exp_st, r), security_state_o);
    compare_value({tag, " dft_en"}, r.dft_req & ~r.scrap_req, soc_dft_en_o);
    compare_value({tag, " hw_debug_en"}, r.hw_dbg_req & ~r.scrap_req, soc_hw_debug_en_o);
    compare_value({tag, " otp_valid"}, otp_data.valid, otp_state_valid_o);
    compare_value({tag, " lc_state"}, otp_data.state, lc_state_o);
  endtask

  task automatic drive_random();
    otp_data.state  = lc_state_e'(rand_bits(5));
    lc_prog.req     = (rand_bits(3) == 0);
    lc_prog.state   = rand_bits(1) ? lc_st_scrap : lc_state_e'(rand_bits(5));
    lc_dft_en       = (rand_bits(2) == 0) ? lc_tx_on : lc_tx_e'(rand_bits(4));
    lc_hw_debug_en  = (rand_bits(2) == 0) ? lc_tx_on : lc_tx_e'(rand_bits(4));
    manuf_dbg_en    = rand_bits(1);
    volatile_unlock = (rand_bits(2) == 0);
    state_error     = (rand_bits(3) == 0);
    warm_reset_warn = (rand_bits(3) == 0);
    // Sparse level and quarter density masks
    unlock_level    = '0;
    if (rand_bits(2) != 0) unlock_level[rand_bits(6) % DbgLevels] = 1'b1;
    dft_mask        = rand_bits(64) & rand_bits(64);
    dbg_mask        = rand_bits(64) & rand_bits(64);
    cltap_mask      = rand_bits(64) & rand_bits(64);
  endtask

  // One change while valid stays high
  task automatic apply_event();
    case (rand_bits(3))
      0: manuf_dbg_en = 1'b1;
      1: volatile_unlock = 1'b1;
      2: begin
        unlock_level = 1;
        dbg_mask[0] = 1'b1;
      end
      3: lc_prog = '{req: 1'b1, state: lc_st_scrap};
      4: state_error = 1'b1;
      5: warm_reset_warn = ~warm_reset_warn;
      6: state_error = 1'b0;
      default: lc_prog.req = 1'b0;
    endcase
  endtask

  // --------------------
  // Scenario loop
  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    lfsr_q = 17'd69330;
    check_cnt = 0;
    err_cnt = 0;
    exp_st = trans_reset;
    otp_data = '0;
    lc_prog = '0;
    lc_dft_en = lc_tx_off;
    lc_hw_debug_en = lc_tx_off;
    manuf_dbg_en = 1'b0;
    volatile_unlock = 1'b0;
    state_error = 1'b0;
    warm_reset_warn = 1'b0;
    unlock_level = '0;
    dft_mask = '0;
    dbg_mask = '0;
    cltap_mask = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int unsigned scen = 0; scen < NumScen; scen++) begin
      otp_data.valid = 1'b0;
      repeat (2) @(negedge clk);
      expect_defaults(scen);
      drive_random();
      otp_data.valid = 1'b1;
      exp_st = settle_state(trans_reset, build_request());
      repeat (8) @(negedge clk);
      check_outputs(scen, "settle");
      apply_event();
      exp_st = settle_state(exp_st, build_request());
      repeat (8) @(negedge clk);
      check_outputs(scen, "event");
    end
    $display("checks %0d, value errors %0d, assertion errors %0d",
             check_cnt, err_cnt, lc_sec_top_i.lc_sec_chk_i.fail_cnt);
    if (err_cnt == 0 && lc_sec_top_i.lc_sec_chk_i.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per scenario
  initial begin
    #(NumScen * 20 * 20);
    $display("watchdog expired before all scenarios finished");
    $display("sim failed");
    $finish;
  end

endmodule

// File: list.f
+incdir+tb
hdl/lc_pkg.sv
hdl/sec_pkg.sv
hdl/lc_decode.sv
hdl/lc_snapshot.sv
hdl/sec_translator.sv
hdl/lc_sec_top.sv
tb/lc_sec_chk.sv
tb/tb_lc_sec.sv
